/* bank_pkg.sv */
// Write-response bank
// Sizes and types shared by the bank
package bank_pkg;

  // Message layout, ID sits in the low bits
  localparam int MsgWidth = 32;
  localparam int IdWidth = 2;
  localparam int NumIds = 2 ** IdWidth;

  // Bank capacity and derived widths
  localparam int NumSlots = 16;
  localparam int SlotAddrWidth = 4;

  // Must hold NumSlots, not just NumSlots-1
  localparam int CountWidth = 5;

  typedef logic [MsgWidth-1:0] msg_t;
  typedef logic [IdWidth-1:0] id_t;
  typedef logic [SlotAddrWidth-1:0] slot_addr_t;
  typedef logic [CountWidth-1:0] count_t;

endpackage

/* slot_ram.sv */
// Slot-indexed flop memory
// One write port, several combinational read ports
module slot_ram #(
  parameter type payload_t = logic,
  parameter int NumReads = 1
) (
  input  logic                 clk_i,
  input  logic                 we_i,
  input  bank_pkg::slot_addr_t waddr_i,
  input  payload_t             wdata_i,
  input  bank_pkg::slot_addr_t raddr_i [NumReads],
  output payload_t             rdata_o [NumReads]
);
  import bank_pkg::*;

  // Storage array, contents only meaningful once written
  payload_t mem_q [NumSlots];

  always_ff @(posedge clk_i) begin
    if (we_i) begin
      mem_q[waddr_i] <= wdata_i;
    end
  end

  // Asynchronous reads
  // A write in the same cycle shows up from the next cycle on
  for (genvar r = 0; r < NumReads; r++) begin : g_read
    assign rdata_o[r] = mem_q[raddr_i[r]];
  end

endmodule

/* free_slot_alloc.sv */
// Free slot allocator
module free_slot_alloc (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          reserve_i,
  input  logic                          release_i,
  input  bank_pkg::slot_addr_t          release_addr_i,
  output bank_pkg::slot_addr_t          free_addr_o,
  output logic                          any_free_o,
  output logic [bank_pkg::NumSlots-1:0] released_onehot_o
);
  import bank_pkg::*;

  // One bit per slot, set while reserved or holding a message
  logic [NumSlots-1:0] occupied_q;
  logic [NumSlots-1:0] occupied_d;
  logic [NumSlots-1:0] reserve_mask;
  logic [NumSlots-1:0] release_mask;

  // Lowest free slot, priority chain from slot 0 upwards
  always_comb begin : p_find_free
    logic found;
    found = 1'b0;
    free_addr_o = '0;
    for (int s = 0; s < NumSlots; s++) begin
      if (!occupied_q[s] && !found) begin
        free_addr_o = slot_addr_t'(s);
        found = 1'b1;
      end
    end
  end

  assign any_free_o = ~&occupied_q;

  always_comb begin
    reserve_mask = '0;
    release_mask = '0;
    if (reserve_i) begin
      reserve_mask[free_addr_o] = 1'b1;
    end
    if (release_i) begin
      release_mask[release_addr_i] = 1'b1;
    end
  end

  assign released_onehot_o = release_mask;

  // Reserved and released slots never collide
  // A reserved slot is free while a released one is occupied
  assign occupied_d = (occupied_q | reserve_mask) & ~release_mask;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      occupied_q <= '0;
    end else begin
      occupied_q <= occupied_d;
    end
  end

endmodule

/* id_list.sv */
// Per-ID linked list controller
module id_list (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 reserve_i,
  input  logic                 fill_i,
  input  logic                 pop_i,
  input  bank_pkg::slot_addr_t free_addr_i,
  input  bank_pkg::slot_addr_t link_next_fill_i,
  input  bank_pkg::slot_addr_t link_next_head_i,
  output bank_pkg::slot_addr_t fill_ptr_o,
  output bank_pkg::slot_addr_t head_ptr_o,
  output bank_pkg::slot_addr_t link_addr_o,
  output logic                 link_we_o,
  output logic                 has_unfilled_o,
  output logic                 has_filled_o
);
  import bank_pkg::*;

  // One chain per ID with filled slots from the head and unfilled ones after them

  // Last reserved slot at the tail of the chain
  slot_addr_t last_q;
  slot_addr_t last_d;
  // Oldest reserved slot still waiting for its message
  slot_addr_t fill_ptr_q;
  slot_addr_t fill_ptr_d;
  // Oldest filled slot and next to be released
  slot_addr_t head_ptr_q;
  slot_addr_t head_ptr_d;

  count_t unfilled_cnt_q;
  count_t unfilled_cnt_d;
  count_t filled_cnt_q;
  count_t filled_cnt_d;

  logic list_empty;
  logic fill_moves_on;
  logic filled_set_empties;

  assign list_empty = (unfilled_cnt_q == '0) && (filled_cnt_q == '0);

  // Another unfilled slot follows the one being filled
  assign fill_moves_on = unfilled_cnt_q > count_t'(1);

  // Filled set has nothing left to point at after this cycle's pop
  assign filled_set_empties = (filled_cnt_q == '0) ||
                              (pop_i && (filled_cnt_q == count_t'(1)));

  // Chain a new reservation behind the current tail
  assign link_addr_o = last_q;
  assign link_we_o   = reserve_i && !list_empty;

  assign last_d = reserve_i ? free_addr_i : last_q;

  always_comb begin
    fill_ptr_d = fill_ptr_q;
    if (fill_i) begin
      if (fill_moves_on) begin
        fill_ptr_d = link_next_fill_i;
      end else if (reserve_i) begin
        // Link is written this very cycle, so bypass it
        fill_ptr_d = free_addr_i;
      end
    end else if (reserve_i && (unfilled_cnt_q == '0)) begin
      fill_ptr_d = free_addr_i;
    end
  end

  always_comb begin
    head_ptr_d = head_ptr_q;
    if (fill_i && filled_set_empties) begin
      head_ptr_d = fill_ptr_q;
    end else if (pop_i && (filled_cnt_q > count_t'(1))) begin
      head_ptr_d = link_next_head_i;
    end
  end

  assign unfilled_cnt_d = unfilled_cnt_q + count_t'(reserve_i) - count_t'(fill_i);
  assign filled_cnt_d   = filled_cnt_q + count_t'(fill_i) - count_t'(pop_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      last_q         <= '0;
      fill_ptr_q     <= '0;
      head_ptr_q     <= '0;
      unfilled_cnt_q <= '0;
      filled_cnt_q   <= '0;
    end else begin
      last_q         <= last_d;
      fill_ptr_q     <= fill_ptr_d;
      head_ptr_q     <= head_ptr_d;
      unfilled_cnt_q <= unfilled_cnt_d;
      filled_cnt_q   <= filled_cnt_d;
    end
  end

  assign fill_ptr_o     = fill_ptr_q;
  assign head_ptr_o     = head_ptr_q;
  assign has_unfilled_o = unfilled_cnt_q != '0;
  assign has_filled_o   = filled_cnt_q != '0;

endmodule

/* release_arbiter.sv */
// Release arbiter and output register
module release_arbiter (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  bank_pkg::slot_addr_t          head_ptr_i [bank_pkg::NumIds],
  input  logic [bank_pkg::NumIds-1:0]   has_filled_i,
  input  logic [bank_pkg::NumSlots-1:0] release_en_i,
  input  logic                          out_ready_i,
  input  bank_pkg::msg_t                rdata_i,
  output logic [bank_pkg::NumIds-1:0]   pop_o,
  output bank_pkg::slot_addr_t          pop_addr_o,
  output bank_pkg::slot_addr_t          out_addr_o,
  output logic                          out_valid_o,
  output bank_pkg::msg_t                data_o
);
  import bank_pkg::*;

  logic [NumIds-1:0] candidate;
  logic [NumIds-1:0] winner;
  logic              any_candidate;
  logic              load;

  logic       out_valid_q;
  slot_addr_t out_addr_q;
  msg_t       data_q;

  // An ID may go when its oldest filled slot is enabled
  for (genvar i = 0; i < NumIds; i++) begin : g_candidate
    assign candidate[i] = has_filled_i[i] && release_en_i[head_ptr_i[i]];
  end

  // Lowest candidate ID wins
  always_comb begin : p_pick
    logic found;
    found = 1'b0;
    winner = '0;
    pop_addr_o = '0;
    for (int i = 0; i < NumIds; i++) begin
      if (candidate[i] && !found) begin
        winner[i] = 1'b1;
        pop_addr_o = head_ptr_i[i];
        found = 1'b1;
      end
    end
  end

  assign any_candidate = |candidate;

  // Register is empty or drains this cycle
  assign load  = !out_valid_q || out_ready_i;
  assign pop_o = load ? winner : '0;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_valid_q <= 1'b0;
    end else if (load) begin
      out_valid_q <= any_candidate;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load && any_candidate) begin
      data_q     <= rdata_i;
      out_addr_q <= pop_addr_o;
    end
  end

  assign out_valid_o = out_valid_q;
  assign out_addr_o  = out_addr_q;
  assign data_o      = data_q;

endmodule

/* resp_bank_top.sv */
// Write-response bank, top level
module resp_bank_top (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  // Reservation
  input  bank_pkg::id_t                 reserve_id_i,
  input  logic                          reserve_ready_i,
  output logic                          reserve_valid_o,
  output bank_pkg::slot_addr_t          new_reserved_address_o,
  // Input messages
  input  logic                          in_valid_i,
  input  bank_pkg::msg_t                data_i,
  output logic                          in_ready_o,
  // Release
  input  logic [bank_pkg::NumSlots-1:0] release_en_i,
  output logic                          out_valid_o,
  input  logic                          out_ready_i,
  output bank_pkg::msg_t                data_o,
  output logic [bank_pkg::NumSlots-1:0] address_released_onehot_o
);
  import bank_pkg::*;

  slot_addr_t free_addr;
  logic       any_free;
  logic       reserve_fire;
  logic       release_fire;
  id_t        in_id;
  slot_addr_t out_addr;

  logic [NumIds-1:0] reserve;
  logic [NumIds-1:0] fill;
  logic [NumIds-1:0] pop;
  logic [NumIds-1:0] link_we;
  logic [NumIds-1:0] has_unfilled;
  logic [NumIds-1:0] has_filled;
  slot_addr_t        fill_ptr [NumIds];
  slot_addr_t        head_ptr [NumIds];
  slot_addr_t        link_addr [NumIds];

  slot_addr_t pop_addr;
  slot_addr_t link_next_fill;
  slot_addr_t link_next_head;

  // Memory port bundles
  slot_addr_t msg_raddr [1];
  msg_t       msg_rdata [1];
  slot_addr_t next_raddr [2];
  slot_addr_t next_rdata [2];

  assign reserve_valid_o        = any_free;
  assign reserve_fire           = reserve_valid_o && reserve_ready_i;
  assign new_reserved_address_o = free_addr;
  assign release_fire           = out_valid_o && out_ready_i;

  assign in_id      = data_i[IdWidth-1:0];
  assign in_ready_o = in_valid_i && has_unfilled[in_id];

  // One-hot strobes by ID
  for (genvar i = 0; i < NumIds; i++) begin : g_strobe
    assign reserve[i] = reserve_fire && (reserve_id_i == id_t'(i));
    assign fill[i]    = in_valid_i && in_ready_o && (in_id == id_t'(i));
  end

  free_slot_alloc i_alloc (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .reserve_i         (reserve_fire),
    .release_i         (release_fire),
    .release_addr_i    (out_addr),
    .free_addr_o       (free_addr),
    .any_free_o        (any_free),
    .released_onehot_o (address_released_onehot_o)
  );

  for (genvar i = 0; i < NumIds; i++) begin : g_id_list
    id_list i_list (
      .clk_i            (clk_i),
      .rst_ni           (rst_ni),
      .reserve_i        (reserve[i]),
      .fill_i           (fill[i]),
      .pop_i            (pop[i]),
      .free_addr_i      (free_addr),
      .link_next_fill_i (link_next_fill),
      .link_next_head_i (link_next_head),
      .fill_ptr_o       (fill_ptr[i]),
      .head_ptr_o       (head_ptr[i]),
      .link_addr_o      (link_addr[i]),
      .link_we_o        (link_we[i]),
      .has_unfilled_o   (has_unfilled[i]),
      .has_filled_o     (has_filled[i])
    );
  end

  // Message storage, written at the fill pointer of the incoming ID
  assign msg_raddr[0] = pop_addr;

  slot_ram #(
    .payload_t (msg_t),
    .NumReads  (1)
  ) i_msg_ram (
    .clk_i   (clk_i),
    .we_i    (in_valid_i && in_ready_o),
    .waddr_i (fill_ptr[in_id]),
    .wdata_i (data_i),
    .raddr_i (msg_raddr),
    .rdata_o (msg_rdata)
  );

  // Next pointers
  // Port 0 follows the fill chain, port 1 the release chain
  assign next_raddr[0]  = fill_ptr[in_id];
  assign next_raddr[1]  = pop_addr;
  assign link_next_fill = next_rdata[0];
  assign link_next_head = next_rdata[1];

  slot_ram #(
    .payload_t (slot_addr_t),
    .NumReads  (2)
  ) i_next_ram (
    .clk_i   (clk_i),
    .we_i    (|link_we),
    .waddr_i (link_addr[reserve_id_i]),
    .wdata_i (free_addr),
    .raddr_i (next_raddr),
    .rdata_o (next_rdata)
  );

  release_arbiter i_arbiter (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .head_ptr_i   (head_ptr),
    .has_filled_i (has_filled),
    .release_en_i (release_en_i),
    .out_ready_i  (out_ready_i),
    .rdata_i      (msg_rdata[0]),
    .pop_o        (pop),
    .pop_addr_o   (pop_addr),
    .out_addr_o   (out_addr),
    .out_valid_o  (out_valid_o),
    .data_o       (data_o)
  );

endmodule

/* tb_resp_bank.sv */
// Write-response bank testbench
// Random traffic checked against a queue model
module tb_resp_bank;
  timeunit 1ns;
  timeprecision 100ps;
  import bank_pkg::*;

  localparam int ResetCycles = 16;
  localparam int StimCycles = 3000;
  // Stimulus length plus a margin for reset and drain
  localparam int TimeoutCycles = StimCycles + 1000;

  logic                clk_i;
  logic                rst_ni;
  id_t                 reserve_id_i;
  logic                reserve_ready_i;
  logic                reserve_valid_o;
  slot_addr_t          new_reserved_address_o;
  logic                in_valid_i;
  msg_t                data_i;
  logic                in_ready_o;
  logic [NumSlots-1:0] release_en_i;
  logic                out_valid_o;
  logic                out_ready_i;
  msg_t                data_o;
  logic [NumSlots-1:0] address_released_onehot_o;

  // Reference model state
  logic [NumSlots-1:0] model_occupied;
  slot_addr_t          unfilled_q [NumIds][$];
  slot_addr_t          filled_addr_q [NumIds][$];
  msg_t                filled_msg_q [NumIds][$];
  // Enable mask seen when the output register last loaded
  logic [NumSlots-1:0] en_at_load;
  // Output register content predicted at the last load
  logic                expect_valid;
  id_t                 expect_id;
  logic                hold_prev;
  msg_t                data_prev;

  int          cycle_count;
  logic [31:0] lcg_state;

  resp_bank_top uut (
    .clk_i                     (clk_i),
    .rst_ni                    (rst_ni),
    .reserve_id_i              (reserve_id_i),
    .reserve_ready_i           (reserve_ready_i),
    .reserve_valid_o           (reserve_valid_o),
    .new_reserved_address_o    (new_reserved_address_o),
    .in_valid_i                (in_valid_i),
    .data_i                    (data_i),
    .in_ready_o                (in_ready_o),
    .release_en_i              (release_en_i),
    .out_valid_o               (out_valid_o),
    .out_ready_i               (out_ready_i),
    .data_o                    (data_o),
    .address_released_onehot_o (address_released_onehot_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TimeoutCycles) begin
      $display("timeout: run did not finish within %0d cycles", TimeoutCycles);
      $display("RESULT: FAIL");
      $fatal(1, "timeout");
    end
  end

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Scan downwards so the lowest free slot is kept
  function automatic slot_addr_t lowest_free_slot();
    slot_addr_t addr;
    addr = '0;
    for (int s = NumSlots - 1; s >= 0; s--) begin
      if (!model_occupied[s]) begin
        addr = slot_addr_t'(s);
      end
    end
    return addr;
  endfunction

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("error at %0d ns: %s mismatch, got 0x%0h, expected 0x%0h",
               $time, what, actual, expected);
      $display("RESULT: FAIL");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  task automatic drive_random_inputs();
    logic [31:0] r;
    logic [31:0] en_a;
    logic [31:0] en_b;
    r = next_random();
    reserve_ready_i = r[31];
    reserve_id_i    = id_t'(r[29:28]);
    in_valid_i      = r[27:26] != 2'b00;
    out_ready_i     = r[25:24] != 2'b00;
    data_i          = next_random();
    en_a = next_random();
    en_b = next_random();
    // Roughly three in four slots enabled
    release_en_i = en_a[31:16] | en_b[31:16];
  endtask

  task automatic check_and_update();
    id_t                 in_id;
    id_t                 out_id;
    slot_addr_t          res_addr;
    slot_addr_t          rel_addr;
    slot_addr_t          moved_addr;
    logic                has_free;
    logic                do_reserve;
    logic                do_fill;
    logic                do_release;
    logic [NumSlots-1:0] expect_onehot;

    in_id      = data_i[IdWidth-1:0];
    has_free   = ~&model_occupied;
    res_addr   = lowest_free_slot();
    do_reserve = has_free && reserve_ready_i;
    do_fill    = in_valid_i && (unfilled_q[in_id].size() != 0);
    do_release = out_valid_o && out_ready_i;

    check_value(32'(out_valid_o), 32'(expect_valid), "out_valid_o");
    if (hold_prev) begin
      check_value(data_o, data_prev, "data_o under back-pressure");
    end

    check_value(32'(reserve_valid_o), 32'(has_free), "reserve_valid_o");
    if (do_reserve) begin
      check_value(32'(new_reserved_address_o), 32'(res_addr), "new_reserved_address_o");
    end

    if (in_valid_i) begin
      check_value(32'(in_ready_o), 32'(do_fill), "in_ready_o");
    end

    if (do_release) begin
      out_id = data_o[IdWidth-1:0];
      check_value(32'(out_id), 32'(expect_id), "released ID");
      check_value(32'(filled_addr_q[out_id].size() != 0), 32'd1,
                  "filled message present for released ID");
      check_value(data_o, filled_msg_q[out_id][0], "data_o");
      rel_addr = filled_addr_q[out_id][0];
      expect_onehot = '0;
      expect_onehot[rel_addr] = 1'b1;
      check_value(32'(address_released_onehot_o), 32'(expect_onehot),
                  "address_released_onehot_o");
      check_value(32'(en_at_load[rel_addr]), 32'd1, "release_en_i of released slot");
      void'(filled_addr_q[out_id].pop_front());
      void'(filled_msg_q[out_id].pop_front());
      model_occupied[rel_addr] = 1'b0;
    end else begin
      check_value(32'(address_released_onehot_o), 32'd0,
                  "address_released_onehot_o outside handshake");
    end

    // Lowest ID whose oldest filled slot is enabled loads next
    if (!out_valid_o || out_ready_i) begin
      en_at_load   = release_en_i;
      expect_valid = 1'b0;
      for (int i = 0; i < NumIds; i++) begin
        if (!expect_valid && (filled_addr_q[i].size() != 0) &&
            release_en_i[filled_addr_q[i][0]]) begin
          expect_valid = 1'b1;
          expect_id    = id_t'(i);
        end
      end
    end

    // Oldest unfilled slot of the ID takes the message
    if (do_fill) begin
      moved_addr = unfilled_q[in_id].pop_front();
      filled_addr_q[in_id].push_back(moved_addr);
      filled_msg_q[in_id].push_back(data_i);
    end

    if (do_reserve) begin
      model_occupied[res_addr] = 1'b1;
      unfilled_q[reserve_id_i].push_back(res_addr);
    end

    hold_prev = out_valid_o && !out_ready_i;
    data_prev = data_o;
  endtask

  initial begin
    lcg_state       = 32'h7d1d17de;
    cycle_count     = 0;
    model_occupied  = '0;
    en_at_load      = '0;
    expect_valid    = 1'b0;
    expect_id       = '0;
    hold_prev       = 1'b0;
    data_prev       = '0;
    rst_ni          = 1'b0;
    reserve_id_i    = '0;
    reserve_ready_i = 1'b0;
    in_valid_i      = 1'b0;
    data_i          = '0;
    release_en_i    = '0;
    out_ready_i     = 1'b0;

    repeat (ResetCycles) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    @(negedge clk_i);
    check_value(32'(out_valid_o), 32'd0, "out_valid_o after reset");
    check_value(32'(address_released_onehot_o), 32'd0, "address_released_onehot_o after reset");
    check_value(32'(reserve_valid_o), 32'd1, "reserve_valid_o after reset");
    check_value(32'(new_reserved_address_o), 32'd0, "new_reserved_address_o after reset");
    check_value(32'(in_ready_o), 32'd0, "in_ready_o after reset");

    for (int c = 0; c < StimCycles; c++) begin
      @(posedge clk_i);
      #1;
      drive_random_inputs();
      @(negedge clk_i);
      check_and_update();
    end

    $display("RESULT: PASS");
    $finish;
  end

endmodule

/* compile.f */
bank_pkg.sv
slot_ram.sv
free_slot_alloc.sv
id_list.sv
release_arbiter.sv
resp_bank_top.sv
tb_resp_bank.sv

/* Makefile */
# Verilator build, run and lint for the write-response bank

VERILATOR ?= verilator
TOP       ?= tb_resp_bank
DUT_TOP   ?= resp_bank_top
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0
LINTFLAGS ?= --lint-only

SIM_BIN     = $(BUILD_DIR)/V$(TOP)
SOURCES     = $(shell grep -v '^+' $(FILELIST))
RTL_SOURCES = $(filter-out $(TOP).sv,$(SOURCES))

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -q '^RESULT: PASS$$' $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(DUT_TOP) $(RTL_SOURCES)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
